//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ns \
  --top-module tb_dbg_mam -Mdir obj_dir -f vlog.f

sim_out=$(./obj_dir/Vtb_dbg_mam)
echo "$sim_out"
echo "$sim_out" | grep -q "Simulation completed successfully"

//--- test/mam_testdata.hex
// Per record: cmd length, rsp length, cmd words (header, addr hi, addr lo, data)
// Second line of each record holds the expected response words
0004 0001 8000 0000 0004 a5c3  // Single write to 0x0004
0001
0003 0001 0000 0000 0004       // Single read back
a5c3
000b 0001 c008 0000 0010 1001 2002 3003 4004 5005 6006 7007 8008  // Burst write 8 at 0x10
0001
0003 0008 4008 0000 0010       // Burst read 8 at 0x10
1001 2002 3003 4004 5005 6006 7007 8008
0003 0001 4001 0000 0012       // Burst read of 1 beat
2002
0003 0001 4000 0000 001e       // Zero beat count reads one word
8008
0004 0001 8000 0000 01fe 5a5a  // Last in-range word
0001
0004 0001 8000 0000 0200 dead  // Write past 512 bytes
0003
0003 0001 0000 0000 0200       // Read past 512 bytes
0000
0003 0001 0000 0000 01fe       // Neighbor keeps its value
5a5a
0003 0008 4008 0000 0010       // Burst read 8 again under stalls
1001 2002 3003 4004 5005 6006 7007 8008
0000 0000

//--- test/tb_dbg_mam.sv
`default_nettype none

module tb_dbg_mam;
  timeunit 1ns;
  timeprecision 1ns;
  import dbg_pkg::*;

  localparam int TIMEOUT    = 2000;  // Cycles allowed for any one wait
  localparam int DATA_WORDS = 256;   // Room for the whole data file

  logic        clk;
  logic        rst;
  logic        cmd_valid;
  logic        cmd_ready;
  dbg_word_t   cmd_data;
  logic        rsp_valid;
  logic        rsp_ready;
  dbg_word_t   rsp_data;

  dbg_word_t   vec [DATA_WORDS];  // Records from the data file
  logic [31:0] lfsr_q;            // Stall pattern source
  int          ptr;               // Next record in vec
  int          tests;
  int          passed;
  int          failed;
  int          mismatches;

  dbg_mam_top u_dut (
    .clk_i       (clk),
    .rst_i       (rst),
    .cmd_valid_i (cmd_valid),
    .cmd_ready_o (cmd_ready),
    .cmd_data_i  (cmd_data),
    .rsp_valid_o (rsp_valid),
    .rsp_ready_i (rsp_ready),
    .rsp_data_o  (rsp_data)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;  // 100 ns period
  end

  ////////////////////
  // Helpers
  ////////////////////

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  function automatic logic draw_ready_bit();
    lfsr_q = lfsr_step(lfsr_q);  // One step per bit
    return lfsr_q[0];
  endfunction

  task automatic abort_on_timeout(input string what);
    $display("Timeout: no %s within %0d cycles", what, TIMEOUT);
    $display("Simulation failed");
    $finish;
  endtask

  task automatic report_test(input string name, input int errs_before);
    tests++;
    if (mismatches == errs_before) begin
      passed++;
      $display("Test %0d %s: PASS", tests, name);
    end else begin
      failed++;
      $display("Test %0d %s: FAIL with %0d errors", tests, name, mismatches - errs_before);
    end
  endtask

  ////////////////////
  // Stream drivers
  ////////////////////

  // Called on a falling edge, returns on a falling edge
  task automatic send_cmd_word(input dbg_word_t w);
    int cycles;
    cycles    = 0;
    cmd_valid = 1'b1;
    cmd_data  = w;
    while (!cmd_ready) begin  // Ready does not depend on valid
      @(negedge clk);
      cycles++;
      if (cycles >= TIMEOUT) abort_on_timeout("cmd_ready_o");
    end
    @(negedge clk);  // Word taken on the rising edge
    cmd_valid = 1'b0;
  endtask

  task automatic expect_rsp_word(input dbg_word_t exp);
    int   cycles;
    logic taken;
    cycles = 0;
    taken  = 1'b0;
    while (!taken) begin
      rsp_ready = draw_ready_bit();  // Random back-pressure
      if (rsp_valid && rsp_ready) begin
        taken = 1'b1;
        if (rsp_data !== exp) begin
          $display("MISMATCH rsp_data_o expected 0x%04h got 0x%04h", exp, rsp_data);
          mismatches++;
        end
      end
      @(negedge clk);
      cycles++;
      if (!taken && cycles >= TIMEOUT) abort_on_timeout("word on rsp_valid_o");
    end
    rsp_ready = 1'b0;
  endtask

  task automatic check_reset_state();
    int errs_before;
    errs_before = mismatches;
    if (cmd_ready !== 1'b1) begin
      $display("MISMATCH cmd_ready_o expected 0x1 got 0x%h", cmd_ready);
      mismatches++;
    end
    if (rsp_valid !== 1'b0) begin
      $display("MISMATCH rsp_valid_o expected 0x0 got 0x%h", rsp_valid);
      mismatches++;
    end
    report_test("reset state", errs_before);
  endtask

  // Lengths first, then command words, then expected response words
  task automatic run_record();
    int cmd_len;
    int rsp_len;
    int errs_before;
    cmd_len     = int'(vec[ptr]);
    rsp_len     = int'(vec[ptr + 1]);
    errs_before = mismatches;
    ptr += 2;
    for (int i = 0; i < cmd_len; i++) send_cmd_word(vec[ptr + i]);
    ptr += cmd_len;
    for (int i = 0; i < rsp_len; i++) expect_rsp_word(vec[ptr + i]);
    ptr += rsp_len;
    if (rsp_valid !== 1'b0) begin  // No word beyond the expected ones
      $display("MISMATCH rsp_valid_o expected 0x0 got 0x%h", rsp_valid);
      mismatches++;
    end
    report_test($sformatf("record (%0d cmd, %0d rsp words)", cmd_len, rsp_len), errs_before);
  endtask

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin
    rst        = 1'b1;
    cmd_valid  = 1'b0;
    cmd_data   = '0;
    rsp_ready  = 1'b0;
    lfsr_q     = 32'h7ec318ff;
    ptr        = 0;
    tests      = 0;
    passed     = 0;
    failed     = 0;
    mismatches = 0;
    for (int i = 0; i < DATA_WORDS; i++) vec[i] = '0;  // Unread words end the list
    $readmemh("test/mam_testdata.hex", vec);
    repeat (4) @(negedge clk);  // Reset held for 4 rising edges
    rst = 1'b0;
    @(negedge clk);
    check_reset_state();
    while (ptr + 1 < DATA_WORDS && vec[ptr] != '0) begin
      if (ptr + 2 + int'(vec[ptr]) + int'(vec[ptr + 1]) > DATA_WORDS) begin
        $display("Data file record at word %0d runs past the end of the file", ptr);
        failed++;
        break;
      end
      run_record();
    end
    $display("Tests run %0d, passed %0d, failed %0d, mismatches %0d",
             tests, passed, failed, mismatches);
    if (failed == 0 && tests > 1) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog/ahb_pkg.sv
`default_nettype none

package ahb_pkg;

  typedef logic [31:0] ahb_addr_t;  // Byte address
  typedef logic [15:0] ahb_data_t;  // Bus data, one halfword

  localparam ahb_addr_t BYTES_PER_BEAT = 32'd2;  // Address step per beat

  ////////////////////
  // Bus encodings
  ////////////////////

  localparam logic [2:0] HBURST_SINGLE    = 3'b000;  // Lone transfer
  localparam logic [2:0] HBURST_INCR      = 3'b001;  // Burst, more beats follow
  localparam logic [2:0] HBURST_INCR_LAST = 3'b111;  // Burst, final beat

  localparam logic [1:0] HTRANS_IDLE   = 2'b00;
  localparam logic [1:0] HTRANS_NONSEQ = 2'b10;  // First beat of a transfer
  localparam logic [1:0] HTRANS_SEQ    = 2'b11;  // Following burst beats

  localparam logic [2:0] HSIZE_HWORD = 3'b001;   // 16-bit beats only
  localparam logic [3:0] HPROT_DATA  = 4'b0011;  // Privileged data access

  // Master to slave
  typedef struct packed {
    logic       hsel;
    ahb_addr_t  haddr;
    ahb_data_t  hwdata;
    logic       hwrite;
    logic [2:0] hsize;
    logic [2:0] hburst;
    logic [3:0] hprot;
    logic [1:0] htrans;
    logic       hmastlock;
  } ahb_m2s_t;

  // Slave to master
  typedef struct packed {
    ahb_data_t hrdata;
    logic      hready;
    logic      hresp;  // Error when high
  } ahb_s2m_t;

endpackage

`default_nettype wire

//--- verilog/ahb_sram.sv
`default_nettype none

module ahb_sram #(
  parameter int MEM_WORDS   = 256,
  parameter int WAIT_STATES = 1
) (
  input  logic               clk_i,
  input  logic               rst_i,
  input  ahb_pkg::ahb_m2s_t  ahb_i,
  output ahb_pkg::ahb_s2m_t  ahb_o
);
  import ahb_pkg::*;

  localparam int IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;
  localparam int CNT_W = $clog2(WAIT_STATES + 2);
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(WAIT_STATES);

  ahb_data_t        mem_q [MEM_WORDS];
  logic [CNT_W-1:0] wait_q;     // Cycles spent on the current beat
  logic [IDX_W-1:0] idx;        // Word index
  logic             active;
  logic             in_range;
  logic             beat_done;

  assign active    = ahb_i.hsel && (ahb_i.htrans != HTRANS_IDLE);
  assign in_range  = (ahb_i.haddr[31:1] < 31'(MEM_WORDS));
  assign idx       = ahb_i.haddr[IDX_W:1];  // Byte address over 2
  assign beat_done = active && ahb_o.hready;

  ////////////////////
  // Response
  ////////////////////

  assign ahb_o.hready = (wait_q == CNT_LAST);
  assign ahb_o.hresp  = active && !in_range;           // Outside the array
  assign ahb_o.hrdata = in_range ? mem_q[idx] : '0;    // Zero when out of range

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wait_q <= '0;
    end else if (!active || ahb_o.hready) begin
      wait_q <= '0;  // Restart for the next beat
    end else begin
      wait_q <= wait_q + CNT_W'(1);
    end
  end

  always_ff @(posedge clk_i) begin
    if (beat_done && ahb_i.hwrite && in_range) mem_q[idx] <= ahb_i.hwdata;
  end

  // Master keeps the beat steady through the wait states
  a_hold_beat: assert property (@(posedge clk_i) disable iff (rst_i)
    active && !ahb_o.hready |=> ahb_i.hsel && $stable(ahb_i.haddr) && $stable(ahb_i.hwdata));

endmodule

`default_nettype wire

//--- verilog/dbg_mam_top.sv
`default_nettype none

module dbg_mam_top (
  input  logic                clk_i,
  input  logic                rst_i,
  input  logic                cmd_valid_i,
  output logic                cmd_ready_o,
  input  dbg_pkg::dbg_word_t  cmd_data_i,
  output logic                rsp_valid_o,
  input  logic                rsp_ready_i,
  output dbg_pkg::dbg_word_t  rsp_data_o
);
  import dbg_pkg::*;
  import ahb_pkg::*;

  ////////////////////
  // Internal links
  ////////////////////

  mam_req_t  req;        // Parser to master
  logic      req_valid;
  logic      req_ready;
  dbg_word_t wr_data;    // Write words
  logic      wr_valid;
  logic      wr_ready;
  dbg_word_t rd_data;    // Master to packer
  logic      rd_valid;
  logic      rd_ready;
  logic      wr_done;
  logic      wr_err;
  logic      stat_busy;  // Status slot taken
  ahb_m2s_t  ahb_m2s;
  ahb_s2m_t  ahb_s2m;

  mam_cmd_parser u_parser (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .cmd_valid_i (cmd_valid_i),
    .cmd_data_i  (cmd_data_i),
    .cmd_ready_o (cmd_ready_o),
    .req_valid_o (req_valid),
    .req_o       (req),
    .req_ready_i (req_ready),
    .wr_valid_o  (wr_valid),
    .wr_data_o   (wr_data),
    .wr_ready_i  (wr_ready)
  );

  mam_ahb_master u_master (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .req_valid_i (req_valid),
    .req_i       (req),
    .req_ready_o (req_ready),
    .wr_valid_i  (wr_valid),
    .wr_data_i   (wr_data),
    .wr_ready_o  (wr_ready),
    .rd_valid_o  (rd_valid),
    .rd_data_o   (rd_data),
    .rd_ready_i  (rd_ready),
    .wr_done_o   (wr_done),
    .wr_err_o    (wr_err),
    .stat_busy_i (stat_busy),
    .ahb_o       (ahb_m2s),
    .ahb_i       (ahb_s2m)
  );

  mam_rsp_packer u_packer (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .rd_valid_i  (rd_valid),
    .rd_data_i   (rd_data),
    .rd_ready_o  (rd_ready),
    .wr_done_i   (wr_done),
    .wr_err_i    (wr_err),
    .stat_busy_o (stat_busy),
    .rsp_valid_o (rsp_valid_o),
    .rsp_data_o  (rsp_data_o),
    .rsp_ready_i (rsp_ready_i)
  );

  ahb_sram #(
    .MEM_WORDS   (256),
    .WAIT_STATES (1)
  ) u_sram (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .ahb_i (ahb_m2s),
    .ahb_o (ahb_s2m)
  );

endmodule

`default_nettype wire

//--- verilog/dbg_pkg.sv
`default_nettype none

package dbg_pkg;

  ////////////////////
  // Stream word types
  ////////////////////

  typedef logic [15:0] dbg_word_t;  // One debug stream word, also the data width
  typedef logic [12:0] beats_t;     // Burst length in words

  // One decoded memory access command
  typedef struct packed {
    logic        we;     // 1 for write, 0 for read
    logic        burst;  // Incrementing burst when set
    beats_t      beats;  // Words to move, never zero once decoded
    logic [31:0] addr;   // Byte address of the first word
  } mam_req_t;

  ////////////////////
  // Header word layout
  ////////////////////

  localparam int HDR_WE_BIT    = 15;  // Write flag
  localparam int HDR_BURST_BIT = 14;  // Burst flag
  localparam int HDR_BEATS_MSB = 12;  // Top of beat count
  localparam int HDR_BEATS_LSB = 0;   // Bottom of beat count

  ////////////////////
  // Write status word
  ////////////////////

  // Sent once per write, after its last beat
  localparam int STAT_DONE_BIT = 0;  // Write finished
  localparam int STAT_ERR_BIT  = 1;  // Some beat got an error response

endpackage

`default_nettype wire

//--- verilog/mam_ahb_master.sv
`default_nettype none

module mam_ahb_master (
  input  logic                clk_i,
  input  logic                rst_i,
  input  logic                req_valid_i,
  input  dbg_pkg::mam_req_t   req_i,
  output logic                req_ready_o,
  input  logic                wr_valid_i,
  input  dbg_pkg::dbg_word_t  wr_data_i,
  output logic                wr_ready_o,
  output logic                rd_valid_o,
  output dbg_pkg::dbg_word_t  rd_data_o,
  input  logic                rd_ready_i,
  output logic                wr_done_o,
  output logic                wr_err_o,
  input  logic                stat_busy_i,
  output ahb_pkg::ahb_m2s_t   ahb_o,
  input  ahb_pkg::ahb_s2m_t   ahb_i
);
  import dbg_pkg::*;
  import ahb_pkg::*;

  typedef enum logic [2:0] {
    IDLE,
    WRITE,
    WRITE_WAIT,
    WRITE_LAST,
    WRITE_LAST_WAIT,
    READ,
    READ_WAIT
  } state_t;

  state_t     state_q;
  state_t     state_d;
  ahb_addr_t  addr_q;     // Address of the current beat
  ahb_data_t  data_q;     // Write data on the bus
  dbg_word_t  rdata_q;    // Captured read word
  logic [2:0] burst_q;    // HBURST of the current beat
  beats_t     beats_q;    // Beats left, current one included until done
  logic       we_q;
  logic       err_q;      // Sticky write error
  logic       first_q;    // No beat done yet in this request
  logic       beat_done;
  logic       last_next;  // Beat ending now leaves one more
  logic       req_fire;

  assign beat_done = ahb_o.hsel && ahb_i.hready;
  assign last_next = (beats_q == beats_t'(2));
  assign req_fire  = req_valid_i && req_ready_o;

  ////////////////////
  // Bus and stream outputs
  ////////////////////

  always_comb begin
    ahb_o.hsel = 1'b0;
    case (state_q)
      WRITE:            ahb_o.hsel = 1'b1;
      WRITE_LAST, READ: ahb_o.hsel = !stat_busy_i;  // Wait for a free response slot
      default:          ahb_o.hsel = 1'b0;
    endcase
    ahb_o.haddr     = addr_q;
    ahb_o.hwdata    = data_q;  // Address and data presented together
    ahb_o.hwrite    = we_q;
    ahb_o.hsize     = HSIZE_HWORD;
    ahb_o.hburst    = burst_q;
    ahb_o.hprot     = HPROT_DATA;
    ahb_o.htrans    = !ahb_o.hsel ? HTRANS_IDLE : (first_q ? HTRANS_NONSEQ : HTRANS_SEQ);
    ahb_o.hmastlock = ahb_o.hsel;  // No real locking
  end

  assign req_ready_o = (state_q == IDLE);
  assign wr_ready_o  = (state_q == WRITE_WAIT) || (state_q == WRITE_LAST_WAIT) ||
                       (state_q == WRITE && beat_done);  // Next word taken as a beat ends
  assign rd_valid_o  = (state_q == READ_WAIT);
  assign rd_data_o   = rdata_q;
  assign wr_done_o   = (state_q == WRITE_LAST) && beat_done;
  assign wr_err_o    = err_q | ahb_i.hresp;  // Last beat counts too

  ////////////////////
  // Next state
  ////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (req_valid_i) begin
          if (!req_i.we) state_d = READ;
          else if (req_i.beats == beats_t'(1)) state_d = WRITE_LAST_WAIT;
          else state_d = WRITE_WAIT;
        end
      end
      WRITE_WAIT:      if (wr_valid_i) state_d = WRITE;
      WRITE_LAST_WAIT: if (wr_valid_i) state_d = WRITE_LAST;
      WRITE: begin
        if (beat_done) begin
          if (last_next) state_d = wr_valid_i ? WRITE_LAST : WRITE_LAST_WAIT;
          else state_d = wr_valid_i ? WRITE : WRITE_WAIT;
        end
      end
      WRITE_LAST: if (beat_done) state_d = IDLE;
      READ:       if (beat_done) state_d = READ_WAIT;
      READ_WAIT: begin
        if (rd_ready_i) state_d = (beats_q == '0) ? IDLE : READ;  // Stall on back-pressure
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= IDLE;
      first_q <= 1'b0;
      err_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      if (req_fire) begin
        first_q <= 1'b1;
        err_q   <= 1'b0;
      end else if (beat_done) begin
        first_q <= 1'b0;
        if (we_q) err_q <= err_q | ahb_i.hresp;
      end
    end
  end

  // Address, count and data
  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      addr_q  <= req_i.addr;
      beats_q <= req_i.beats;
      we_q    <= req_i.we;
      if (!req_i.burst) burst_q <= HBURST_SINGLE;
      else if (req_i.beats == beats_t'(1)) burst_q <= HBURST_INCR_LAST;
      else burst_q <= HBURST_INCR;
    end else if (beat_done) begin
      addr_q  <= addr_q + BYTES_PER_BEAT;
      beats_q <= beats_q - beats_t'(1);
      if (last_next) burst_q <= HBURST_INCR_LAST;  // Mark the final beat
      if (!we_q) rdata_q <= ahb_i.hrdata;
    end
    if (wr_ready_o && wr_valid_i) data_q <= wr_data_i;
  end

  a_idle_no_hsel: assert property (@(posedge clk_i) disable iff (rst_i)
    (state_q == IDLE) |-> !ahb_o.hsel);

  // Read word holds steady until the packer takes it
  a_rd_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    rd_valid_o && !rd_ready_i |=> rd_valid_o && $stable(rd_data_o));

endmodule

`default_nettype wire

//--- verilog/mam_cmd_parser.sv
`default_nettype none

module mam_cmd_parser (
  input  logic                clk_i,
  input  logic                rst_i,
  input  logic                cmd_valid_i,
  input  dbg_pkg::dbg_word_t  cmd_data_i,
  output logic                cmd_ready_o,
  output logic                req_valid_o,
  output dbg_pkg::mam_req_t   req_o,
  input  logic                req_ready_i,
  output logic                wr_valid_o,
  output dbg_pkg::dbg_word_t  wr_data_o,
  input  logic                wr_ready_i
);
  import dbg_pkg::*;

  typedef enum logic [2:0] {HEADER, ADDR_HI, ADDR_LO, REQ, DATA} state_t;

  state_t   state_q;
  mam_req_t req_q;      // Command being collected
  beats_t   cnt_q;      // Write words still to forward
  logic     cmd_fire;
  beats_t   hdr_beats;
  logic     hdr_burst;

  assign cmd_fire  = cmd_valid_i && cmd_ready_o;
  assign hdr_beats = cmd_data_i[HDR_BEATS_MSB:HDR_BEATS_LSB];
  assign hdr_burst = cmd_data_i[HDR_BURST_BIT];

  ////////////////////
  // Stream handshakes
  ////////////////////

  always_comb begin
    cmd_ready_o = 1'b0;
    wr_valid_o  = 1'b0;
    wr_data_o   = cmd_data_i;  // Data words pass straight through
    case (state_q)
      HEADER, ADDR_HI, ADDR_LO: cmd_ready_o = 1'b1;
      DATA: begin
        cmd_ready_o = wr_ready_i;  // Ready joined to the master
        wr_valid_o  = cmd_valid_i;
      end
      default: cmd_ready_o = 1'b0;  // REQ holds off the host
    endcase
  end

  assign req_valid_o = (state_q == REQ);
  assign req_o       = req_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= HEADER;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        HEADER:  if (cmd_fire) state_q <= ADDR_HI;
        ADDR_HI: if (cmd_fire) state_q <= ADDR_LO;
        ADDR_LO: if (cmd_fire) state_q <= REQ;
        REQ: begin
          if (req_ready_i) begin
            state_q <= req_q.we ? DATA : HEADER;  // Reads carry no data
            cnt_q   <= req_q.beats;
          end
        end
        DATA: begin
          if (cmd_fire) begin
            cnt_q <= cnt_q - beats_t'(1);
            if (cnt_q == beats_t'(1)) state_q <= HEADER;  // Last word of the write
          end
        end
        default: state_q <= HEADER;
      endcase
    end
  end

  // Command fields
  always_ff @(posedge clk_i) begin
    if (cmd_fire && state_q == HEADER) begin
      req_q.we    <= cmd_data_i[HDR_WE_BIT];
      req_q.burst <= hdr_burst;
      // Non-burst or zero count means one word
      req_q.beats <= (hdr_burst && hdr_beats != '0) ? hdr_beats : beats_t'(1);
    end
    if (cmd_fire && state_q == ADDR_HI) req_q.addr[31:16] <= cmd_data_i;  // High word first
    if (cmd_fire && state_q == ADDR_LO) req_q.addr[15:0]  <= cmd_data_i;
  end

  a_req_beats: assert property (@(posedge clk_i) disable iff (rst_i)
    (state_q == REQ) |-> (req_q.beats != '0));

endmodule

`default_nettype wire

//--- verilog/mam_rsp_packer.sv
`default_nettype none

module mam_rsp_packer (
  input  logic                clk_i,
  input  logic                rst_i,
  input  logic                rd_valid_i,
  input  dbg_pkg::dbg_word_t  rd_data_i,
  output logic                rd_ready_o,
  input  logic                wr_done_i,
  input  logic                wr_err_i,
  output logic                stat_busy_o,
  output logic                rsp_valid_o,
  output dbg_pkg::dbg_word_t  rsp_data_o,
  input  logic                rsp_ready_i
);
  import dbg_pkg::*;

  dbg_word_t stat_q;       // Status word waiting to go out
  logic      stat_pend_q;
  dbg_word_t stat_word;

  always_comb begin
    stat_word                = '0;
    stat_word[STAT_DONE_BIT] = 1'b1;
    stat_word[STAT_ERR_BIT]  = wr_err_i;
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      stat_pend_q <= 1'b0;
    end else if (wr_done_i) begin
      stat_pend_q <= 1'b1;
    end else if (stat_pend_q && rsp_ready_i) begin
      stat_pend_q <= 1'b0;  // Host took it
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_done_i) stat_q <= stat_word;
  end

  ////////////////////
  // Output mux
  ////////////////////

  assign stat_busy_o = stat_pend_q;
  assign rsp_valid_o = stat_pend_q || rd_valid_i;
  assign rsp_data_o  = stat_pend_q ? stat_q : rd_data_i;  // Reads pass without a register
  assign rd_ready_o  = rsp_ready_i && !stat_pend_q;

  a_no_rd_with_stat: assert property (@(posedge clk_i) disable iff (rst_i)
    !(rd_valid_i && stat_pend_q));

  // Master must hold the next write while a status is queued
  a_done_when_free: assert property (@(posedge clk_i) disable iff (rst_i)
    wr_done_i |-> !stat_pend_q);

endmodule

`default_nettype wire

//--- vlog.f
verilog/dbg_pkg.sv
verilog/ahb_pkg.sv
verilog/mam_cmd_parser.sv
verilog/mam_ahb_master.sv
verilog/mam_rsp_packer.sv
verilog/ahb_sram.sv
verilog/dbg_mam_top.sv
test/tb_dbg_mam.sv
